// File: logic/cpu_cfg.svh
/* system constants for the 128 KB map; only the low CPU_ADDR_W address bits are decoded,
   so RAM aliases above 0x1FFFF except at the two IO words */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// byte address bits that reach the bus
`define CPU_ADDR_W    18

`define CPU_RAM_BYTES 131072        // 128 KB RAM from address 0

// memory mapped IO, write side only
`define CPU_IO_OUT    32'h0003_0000 // byte out to the UART
`define CPU_IO_HALT   32'h0003_0004 // any write stops the core

`define CPU_RESET_PC  32'h0000_0000 // first fetch after arst_n

`endif

// File: logic/cpu_pkg.sv
/* shared types of the core; addr_t follows CPU_ADDR_W from the config header */
`include "cpu_cfg.svh"

package cpu_pkg;

  typedef logic [31:0]              word_t;    // data word and PC
  typedef logic [`CPU_ADDR_W-1:0]   addr_t;    // byte address on the bus
  typedef logic [4:0]               reg_idx_t; // x0..x31
  typedef logic [7:0]               byte_t;    // one bus transfer

  // instruction class out of the decoder
  typedef enum logic [2:0] {
    OC_LUI,
    OC_ALU_IMM,
    OC_ALU_REG,
    OC_LOAD,
    OC_STORE,
    OC_BRANCH,
    OC_JAL,
    OC_ILLEGAL  // anything outside the subset
  } op_class_e;

  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR, SLT, SLL, SRL,
    EQ, NE      // branch compares
  } alu_op_e;

  // sequencer phases, one instruction at a time
  typedef enum logic [2:0] {
    FETCH, DECODE, EXEC, MEM, WB, HALTED
  } ctrl_state_e;

  typedef enum logic [1:0] {
    IDLE, ISSUE, LAST, ACK
  } mem_state_e;

  typedef enum logic {
    SZ_BYTE, SZ_WORD
  } acc_size_e;

endpackage

// File: logic/mem_ctrl.sv
/* byte bus sequencer; word accesses go out LSB first, read data comes back one cycle
   after its address and is only kept when rdy_in was high in both cycles */
`include "cpu_cfg.svh"
`timescale 1ns/10ps

module mem_ctrl
(
  input  logic               clk_in,
  input  logic               arst_n,
  input  logic               rdy_in,
  input  logic               io_buffer_full,
  input  logic               mem_req,
  input  logic               mem_we,
  input  cpu_pkg::acc_size_e mem_size,
  input  cpu_pkg::addr_t     mem_addr,
  input  cpu_pkg::word_t     mem_wdata,
  output logic               mem_ack,
  output cpu_pkg::word_t     mem_rdata,
  input  cpu_pkg::byte_t     mem_din,
  output cpu_pkg::byte_t     mem_dout,
  output logic [31:0]        mem_a,
  output logic               mem_wr
);
  import cpu_pkg::*;

  mem_state_e state;
  logic [1:0] cnt;      // next byte to address
  logic [1:0] last;     // index of final byte
  logic [1:0] idx;      // byte on the bus this cycle
  logic [1:0] cap_idx;  // byte that mem_din belongs to
  logic       pend;     // last cycle drove a read address with rdy_in high
  logic       reissue;
  logic       hold_io;
  addr_t      cur_addr;
  word_t      rbuf;     // read bytes as they arrive

  assign last    = (mem_size == SZ_WORD) ? 2'd3 : 2'd0;
  // a read byte got lost to rdy_in, so drive its address again
  assign reissue = (state == ISSUE) && !mem_we && (cnt != 2'd0) && !pend;
  assign idx     = reissue ? cnt - 2'd1 : cnt;
  assign cap_idx = (state == LAST) ? cnt : cnt - 2'd1;

  // UART write waits here while its buffer is full
  assign hold_io  = mem_we && (mem_addr == addr_t'(`CPU_IO_OUT)) && io_buffer_full;
  assign cur_addr = mem_addr + addr_t'(idx);

  assign mem_a     = ((state == ISSUE) || (state == LAST)) ? 32'(cur_addr) : 32'd0;
  assign mem_dout  = mem_wdata[{idx, 3'b000} +: 8];
  assign mem_wr    = rdy_in && (state == ISSUE) && mem_we && !hold_io;
  assign mem_ack   = (state == ACK);
  assign mem_rdata = (mem_size == SZ_BYTE) ? {24'd0, rbuf[7:0]} : rbuf;  // lbu zero-extends

  always_ff @(posedge clk_in or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state <= IDLE;
      cnt   <= 2'd0;
    end
    else if (rdy_in)
    begin
      case (state)
        IDLE:
          if (mem_req)
          begin
            cnt   <= 2'd0;
            state <= ISSUE;
          end
        ISSUE:
          if (mem_we ? !hold_io : !reissue)
          begin
            if (cnt == last)
              state <= mem_we ? ACK : LAST;  // reads still owe the final byte
            else
              cnt <= cnt + 2'd1;
          end
        LAST:
          if (pend)
            state <= ACK;
        ACK:
          if (!mem_req)
            state <= IDLE;
        default:
          state <= IDLE;
      endcase
    end
  end

  // tracks rdy_in of the address cycle, so it keeps running while the rest holds
  always_ff @(posedge clk_in or negedge arst_n)
  begin
    if (!arst_n)
      pend <= 1'b0;
    else
      pend <= rdy_in && !mem_we && ((state == ISSUE) || ((state == LAST) && !pend));
  end

  always_ff @(posedge clk_in)
  begin
    if (rdy_in && pend)
      rbuf[{cap_idx, 3'b000} +: 8] <= mem_din;
  end

endmodule

// File: logic/decoder.sv
/* decodes the supported RV32I subset only; shifts by immediate, SLTIU, SRA, JALR
   and every other opcode come out as OC_ILLEGAL */
`timescale 1ns/10ps

module decoder
(
  input  cpu_pkg::word_t     instr,
  output cpu_pkg::op_class_e op_class,
  output cpu_pkg::alu_op_e   alu_op,
  output cpu_pkg::reg_idx_t  rs1,
  output cpu_pkg::reg_idx_t  rs2,
  output cpu_pkg::reg_idx_t  rd,
  output cpu_pkg::word_t     imm,
  output cpu_pkg::acc_size_e size
);
  import cpu_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  // all immediates sign-extend from bit 31
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'd0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb
  begin
    op_class = OC_ILLEGAL;
    alu_op   = ADD;    // address and link arithmetic
    imm      = imm_i;
    size     = SZ_WORD;
    case (opcode)
      7'b0110111:
      begin
        op_class = OC_LUI;
        imm      = imm_u;
      end
      7'b0010011:
      begin
        op_class = OC_ALU_IMM;
        case (funct3)
          3'b000:  alu_op = ADD;
          3'b010:  alu_op = SLT;
          3'b100:  alu_op = XOR;
          3'b110:  alu_op = OR;
          3'b111:  alu_op = AND;
          default: op_class = OC_ILLEGAL;
        endcase
      end
      7'b0110011:
      begin
        op_class = OC_ALU_REG;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: alu_op = ADD;
          {7'b0100000, 3'b000}: alu_op = SUB;
          {7'b0000000, 3'b001}: alu_op = SLL;
          {7'b0000000, 3'b010}: alu_op = SLT;
          {7'b0000000, 3'b100}: alu_op = XOR;
          {7'b0000000, 3'b101}: alu_op = SRL;
          {7'b0000000, 3'b110}: alu_op = OR;
          {7'b0000000, 3'b111}: alu_op = AND;
          default:              op_class = OC_ILLEGAL;
        endcase
      end
      7'b0000011:          // lw, lbu
      begin
        op_class = (funct3 == 3'b010 || funct3 == 3'b100) ? OC_LOAD : OC_ILLEGAL;
        size     = (funct3 == 3'b100) ? SZ_BYTE : SZ_WORD;
      end
      7'b0100011:          // sw, sb
      begin
        op_class = (funct3 == 3'b010 || funct3 == 3'b000) ? OC_STORE : OC_ILLEGAL;
        imm      = imm_s;
        size     = (funct3 == 3'b000) ? SZ_BYTE : SZ_WORD;
      end
      7'b1100011:          // beq, bne
      begin
        op_class = (funct3[2:1] == 2'b00) ? OC_BRANCH : OC_ILLEGAL;
        alu_op   = funct3[0] ? NE : EQ;
        imm      = imm_b;
      end
      7'b1101111:
      begin
        op_class = OC_JAL;
        imm      = imm_j;
      end
      default: ;
    endcase
  end

endmodule

// File: logic/alu.sv
/* single-cycle ALU; SLT is signed, shifts use b[4:0], no arithmetic right shift */
`timescale 1ns/10ps

module alu
(
  input  cpu_pkg::word_t   a,
  input  cpu_pkg::word_t   b,
  input  cpu_pkg::alu_op_e op,
  output cpu_pkg::word_t   result,
  output logic             taken
);
  import cpu_pkg::*;

  logic eq;
  logic lt;

  assign eq = (a == b);
  assign lt = ($signed(a) < $signed(b));

  always_comb
  begin
    case (op)
      ADD:     result = a + b;
      SUB:     result = a - b;
      AND:     result = a & b;
      OR:      result = a | b;
      XOR:     result = a ^ b;
      SLT:     result = {31'd0, lt};
      SLL:     result = a << b[4:0];
      SRL:     result = a >> b[4:0];  // logical
      EQ:      result = {31'd0, eq};
      NE:      result = {31'd0, !eq};
      default: result = '0;
    endcase
  end

  // branch decision for beq/bne
  assign taken = ((op == EQ) && eq) || ((op == NE) && !eq);

endmodule

// File: logic/reg_file.sv
/* 32 x 32 registers, two async reads, one write; x0 is never written */
`timescale 1ns/10ps

module reg_file
(
  input  logic              clk_in,
  input  logic              arst_n,
  input  logic              rdy_in,
  input  cpu_pkg::reg_idx_t raddr1,
  input  cpu_pkg::reg_idx_t raddr2,
  output cpu_pkg::word_t    rdata1,
  output cpu_pkg::word_t    rdata2,
  input  logic              we,
  input  cpu_pkg::reg_idx_t waddr,
  input  cpu_pkg::word_t    wdata
);
  import cpu_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk_in or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end
    else if (rdy_in && we && (waddr != reg_idx_t'(0)))
      regs[waddr] <= wdata;  // x0 stays zero
  end

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule

// File: logic/core_ctrl.sv
/* in-order multi-cycle sequencer; one instruction in flight, stores to the halt word
   go out as a single byte, illegal opcodes halt until arst_n */
`include "cpu_cfg.svh"
`timescale 1ns/10ps

module core_ctrl
(
  input  logic               clk_in,
  input  logic               arst_n,
  input  logic               rdy_in,
  input  cpu_pkg::op_class_e op_class,
  input  cpu_pkg::alu_op_e   alu_op,
  input  cpu_pkg::reg_idx_t  rs1,
  input  cpu_pkg::reg_idx_t  rs2,
  input  cpu_pkg::reg_idx_t  rd,
  input  cpu_pkg::word_t     imm,
  input  cpu_pkg::acc_size_e size,
  output cpu_pkg::word_t     instr,
  output cpu_pkg::word_t     alu_a,
  output cpu_pkg::word_t     alu_b,
  output cpu_pkg::alu_op_e   alu_fn,
  input  cpu_pkg::word_t     alu_result,
  input  logic               alu_taken,
  output cpu_pkg::reg_idx_t  rf_raddr1,
  output cpu_pkg::reg_idx_t  rf_raddr2,
  input  cpu_pkg::word_t     rf_rdata1,
  input  cpu_pkg::word_t     rf_rdata2,
  output logic               rf_we,
  output cpu_pkg::reg_idx_t  rf_waddr,
  output cpu_pkg::word_t     rf_wdata,
  output logic               mem_req,
  output logic               mem_we,
  output cpu_pkg::acc_size_e mem_size,
  output cpu_pkg::addr_t     mem_addr,
  output cpu_pkg::word_t     mem_wdata,
  input  logic               mem_ack,
  input  cpu_pkg::word_t     mem_rdata
);
  import cpu_pkg::*;

  ctrl_state_e state;
  word_t       pc;
  word_t       pc_plus4;
  word_t       res;      // alu result, also load/store address and jal target
  word_t       ldata;
  logic        taken_q;
  logic        hs_free;  // previous handshake fully closed
  logic        hs_done;
  logic        to_halt;
  logic        is_mem;

  assign pc_plus4  = pc + 32'd4;
  assign hs_free   = !mem_req && !mem_ack;
  assign hs_done   = mem_req && mem_ack;
  assign to_halt   = (res[`CPU_ADDR_W-1:0] == addr_t'(`CPU_IO_HALT));
  assign is_mem    = (op_class == OC_LOAD) || (op_class == OC_STORE);

  assign rf_raddr1 = rs1;
  assign rf_raddr2 = rs2;
  assign alu_fn    = alu_op;

  // operand select
  always_comb
  begin
    alu_a = rf_rdata1;
    alu_b = imm;
    case (op_class)
      OC_LUI:     alu_a = '0;         // imm passes through
      OC_ALU_REG,
      OC_BRANCH:  alu_b = rf_rdata2;
      OC_JAL:     alu_a = pc;         // target = pc + imm
      default: ;
    endcase
  end

  // bus lines stay stable from req up to ack
  assign mem_addr  = (state == MEM) ? res[`CPU_ADDR_W-1:0] : pc[`CPU_ADDR_W-1:0];
  assign mem_we    = (state == MEM) && (op_class == OC_STORE);
  assign mem_size  = (state != MEM) ? SZ_WORD : (to_halt ? SZ_BYTE : size);
  assign mem_wdata = rf_rdata2;

  assign rf_we    = (state == WB) && (op_class inside {OC_LUI, OC_ALU_IMM, OC_ALU_REG,
                                                       OC_LOAD, OC_JAL});
  assign rf_waddr = rd;
  assign rf_wdata = (op_class == OC_LOAD) ? ldata :
                    (op_class == OC_JAL)  ? pc_plus4 : res;

  always_ff @(posedge clk_in or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state   <= FETCH;
      pc      <= `CPU_RESET_PC;
      mem_req <= 1'b0;
      taken_q <= 1'b0;
    end
    else if (rdy_in)
    begin
      case (state)
        FETCH, MEM:
          if (hs_free)
            mem_req <= 1'b1;
          else if (hs_done)
          begin
            mem_req <= 1'b0;
            if (state == FETCH)
              state <= DECODE;
            else
              state <= (mem_we && to_halt) ? HALTED : WB;
          end
        DECODE:
          state <= (op_class == OC_ILLEGAL) ? HALTED : EXEC;
        EXEC:
        begin
          taken_q <= alu_taken;
          state   <= is_mem ? MEM : WB;
        end
        WB:
        begin
          if (op_class == OC_JAL)
            pc <= res;
          else if ((op_class == OC_BRANCH) && taken_q)
            pc <= pc + imm;
          else
            pc <= pc_plus4;
          state <= FETCH;
        end
        default: ;  // HALTED until reset
      endcase
    end
  end

  always_ff @(posedge clk_in)
  begin
    if (rdy_in)
    begin
      if ((state == FETCH) && hs_done)
        instr <= mem_rdata;
      if (state == EXEC)
        res <= alu_result;
      if ((state == MEM) && hs_done)
        ldata <= mem_rdata;  // already zero-extended for lbu
    end
  end

endmodule

// File: logic/cpu.sv
/* RV32I subset CPU on a byte memory bus; rdy_in low freezes all state,
   io_buffer_full holds writes to the UART port, mem_a[31:18] are always zero */
`timescale 1ns/10ps

module cpu
(
  input  logic           clk_in,
  input  logic           arst_n,
  input  logic           rdy_in,
  input  cpu_pkg::byte_t mem_din,         // read byte, one cycle after mem_a
  output cpu_pkg::byte_t mem_dout,
  output logic [31:0]    mem_a,
  output logic           mem_wr,          // 1 for write
  input  logic           io_buffer_full   // uart cannot take a byte
);
  import cpu_pkg::*;

  // decoder
  word_t     instr;
  op_class_e op_class;
  alu_op_e   dec_op;
  reg_idx_t  rs1;
  reg_idx_t  rs2;
  reg_idx_t  rd;
  word_t     imm;
  acc_size_e size;
  // alu
  word_t     alu_a;
  word_t     alu_b;
  alu_op_e   alu_fn;
  word_t     alu_result;
  logic      alu_taken;
  // register file
  reg_idx_t  rf_raddr1;
  reg_idx_t  rf_raddr2;
  word_t     rf_rdata1;
  word_t     rf_rdata2;
  logic      rf_we;
  reg_idx_t  rf_waddr;
  word_t     rf_wdata;
  // req/ack link to the memory controller
  logic      mem_req;
  logic      mem_we;
  acc_size_e mem_size;
  addr_t     mem_addr;
  word_t     mem_wdata;
  logic      mem_ack;
  word_t     mem_rdata;

  core_ctrl core_ctrl_inst
  (
    .clk_in     (clk_in),
    .arst_n     (arst_n),
    .rdy_in     (rdy_in),
    .op_class   (op_class),
    .alu_op     (dec_op),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .imm        (imm),
    .size       (size),
    .instr      (instr),
    .alu_a      (alu_a),
    .alu_b      (alu_b),
    .alu_fn     (alu_fn),
    .alu_result (alu_result),
    .alu_taken  (alu_taken),
    .rf_raddr1  (rf_raddr1),
    .rf_raddr2  (rf_raddr2),
    .rf_rdata1  (rf_rdata1),
    .rf_rdata2  (rf_rdata2),
    .rf_we      (rf_we),
    .rf_waddr   (rf_waddr),
    .rf_wdata   (rf_wdata),
    .mem_req    (mem_req),
    .mem_we     (mem_we),
    .mem_size   (mem_size),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_ack    (mem_ack),
    .mem_rdata  (mem_rdata)
  );

  decoder decoder_inst
  (
    .instr    (instr),
    .op_class (op_class),
    .alu_op   (dec_op),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .imm      (imm),
    .size     (size)
  );

  alu alu_inst
  (
    .a      (alu_a),
    .b      (alu_b),
    .op     (alu_fn),
    .result (alu_result),
    .taken  (alu_taken)
  );

  reg_file reg_file_inst
  (
    .clk_in (clk_in),
    .arst_n (arst_n),
    .rdy_in (rdy_in),
    .raddr1 (rf_raddr1),
    .raddr2 (rf_raddr2),
    .rdata1 (rf_rdata1),
    .rdata2 (rf_rdata2),
    .we     (rf_we),
    .waddr  (rf_waddr),
    .wdata  (rf_wdata)
  );

  mem_ctrl mem_ctrl_inst
  (
    .clk_in         (clk_in),
    .arst_n         (arst_n),
    .rdy_in         (rdy_in),
    .io_buffer_full (io_buffer_full),
    .mem_req        (mem_req),
    .mem_we         (mem_we),
    .mem_size       (mem_size),
    .mem_addr       (mem_addr),
    .mem_wdata      (mem_wdata),
    .mem_ack        (mem_ack),
    .mem_rdata      (mem_rdata),
    .mem_din        (mem_din),
    .mem_dout       (mem_dout),
    .mem_a          (mem_a),
    .mem_wr         (mem_wr)
  );

endmodule

// File: bench/cpu_assertions.sv
/* bus protocol properties bound into cpu and disabled while arst_n is low */
`include "cpu_cfg.svh"
`timescale 1ns/10ps

module cpu_assertions
(
  input logic        clk_in,
  input logic        arst_n,
  input logic        rdy_in,
  input logic        io_buffer_full,
  input logic        mem_wr,
  input logic [31:0] mem_a,
  input logic        mem_req,
  input logic        mem_ack
);
  int violations = 0;

  // a frozen core must not write
  wr_needs_rdy: assert property (@(posedge clk_in) disable iff (!arst_n)
    mem_wr |-> rdy_in)
  else
  begin
    $error("mem_wr high while rdy_in is low");
    violations++;
  end

  // uart byte only when the buffer has room
  io_needs_room: assert property (@(posedge clk_in) disable iff (!arst_n)
    (mem_wr && (mem_a == `CPU_IO_OUT)) |-> !io_buffer_full)
  else
  begin
    $error("write to the output port while io_buffer_full is high");
    violations++;
  end

  ack_needs_req: assert property (@(posedge clk_in) disable iff (!arst_n)
    $rose(mem_ack) |-> mem_req)  // req is held until ack shows up
  else
  begin
    $error("mem_ack rose without mem_req");
    violations++;
  end

endmodule

// File: bench/cpu_checker.sv
/* instruction-set model of the supported subset; predicts the ordered bus byte writes
   and compares them with every mem_wr cycle including the halt write */
`include "cpu_cfg.svh"
`timescale 1ns/10ps

module cpu_checker
(
  input logic           clk_in,
  input logic           rdy_in,
  input logic           mem_wr,
  input logic [31:0]    mem_a,
  input cpu_pkg::byte_t mem_dout
);
  import cpu_pkg::*;

  byte_t ram [`CPU_RAM_BYTES];  // model copy of program and data
  word_t exp_a [$];             // predicted write addresses in bus order
  byte_t exp_d [$];
  int    test_errs;
  int    seen;                  // writes matched in this test
  int    passed = 0;
  int    failed = 0;

  task automatic load_byte(input word_t addr, input byte_t d);
    ram[addr[16:0]] = d;
  endtask

  function automatic word_t read_word(input word_t addr);
    return {ram[addr[16:0] + 17'd3], ram[addr[16:0] + 17'd2],
            ram[addr[16:0] + 17'd1], ram[addr[16:0]]};  // little-endian
  endfunction

  // queue one bus byte and mirror RAM bytes into the model copy
  task automatic expect_write(input word_t addr, input byte_t d);
    exp_a.push_back(32'(addr_t'(addr)));
    exp_d.push_back(d);
    if (addr < `CPU_RAM_BYTES)
      ram[addr[16:0]] = d;
  endtask

  task automatic run_model();
    word_t x [32];
    word_t pc;
    word_t nxt;
    word_t ins;
    word_t a;         // rs1 value
    word_t b;         // rs2 value
    word_t ea;        // load/store address
    word_t v;
    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_j;
    logic  wr;
    logic  bad;
    logic  run;
    int    steps;
    exp_a.delete();
    exp_d.delete();
    test_errs = 0;
    seen      = 0;
    foreach (x[i])
      x[i] = '0;
    pc    = `CPU_RESET_PC;
    run   = 1'b1;
    steps = 0;
    while (run && (steps < 1000))
    begin
      ins   = read_word(pc);
      a     = x[ins[19:15]];
      b     = x[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      nxt   = pc + 32'd4;
      wr    = 1'b1;
      bad   = 1'b0;
      v     = '0;
      case (ins[6:0])
        7'b0110111: v = {ins[31:12], 12'd0};  // lui
        7'b0010011:
          case (ins[14:12])
            3'b000:  v = a + imm_i;
            3'b010:  v = ($signed(a) < $signed(imm_i)) ? 32'd1 : 32'd0;
            3'b100:  v = a ^ imm_i;
            3'b110:  v = a | imm_i;
            3'b111:  v = a & imm_i;
            default: bad = 1'b1;
          endcase
        7'b0110011:
          case ({ins[31:25], ins[14:12]})
            10'b0000000_000: v = a + b;
            10'b0100000_000: v = a - b;
            10'b0000000_001: v = a << b[4:0];
            10'b0000000_010: v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            10'b0000000_100: v = a ^ b;
            10'b0000000_101: v = a >> b[4:0];
            10'b0000000_110: v = a | b;
            10'b0000000_111: v = a & b;
            default:         bad = 1'b1;
          endcase
        7'b0000011:
        begin
          ea = a + imm_i;
          if (ins[14:12] == 3'b010)
            v = read_word(ea);
          else if (ins[14:12] == 3'b100)
            v = {24'd0, ram[ea[16:0]]};  // lbu
          else
            bad = 1'b1;
        end
        7'b0100011:
        begin
          wr = 1'b0;
          ea = a + imm_s;
          if ((ins[14:12] != 3'b000) && (ins[14:12] != 3'b010))
            bad = 1'b1;
          else if (ea == `CPU_IO_HALT)
          begin
            expect_write(ea, b[7:0]);  // halt is always one byte
            run = 1'b0;
          end
          else
            for (int k = 0; k < ((ins[14:12] == 3'b010) ? 4 : 1); k++)
              expect_write(ea + k, b[k*8 +: 8]);
        end
        7'b1100011:
        begin
          wr = 1'b0;
          if (ins[14:12] == 3'b000)
            nxt = (a == b) ? pc + imm_b : nxt;
          else if (ins[14:12] == 3'b001)
            nxt = (a != b) ? pc + imm_b : nxt;
          else
            bad = 1'b1;
        end
        7'b1101111:
        begin
          v   = pc + 32'd4;  // link
          nxt = pc + imm_j;
        end
        default: bad = 1'b1;
      endcase
      if (bad)
        run = 1'b0;         // core halts here and writes nothing
      else if (wr && (ins[11:7] != 5'd0))
        x[ins[11:7]] = v;
      pc = nxt;
      steps++;
    end
  endtask

  always @(posedge clk_in)
  begin
    if (mem_wr && rdy_in)
    begin
      if (exp_a.size() == 0)
      begin
        $display("%0d ns: unexpected write of %h to %h after the predicted stream ended",
                 $time, mem_dout, mem_a);
        test_errs++;
      end
      else
      begin
        if (mem_a !== exp_a[0])
        begin
          $display("[FAIL] %0d ns mem_a expected %h got %h", $time, exp_a[0], mem_a);
          test_errs++;
        end
        if (mem_dout !== exp_d[0])
        begin
          $display("[FAIL] %0d ns mem_dout expected %h got %h", $time, exp_d[0], mem_dout);
          test_errs++;
        end
        void'(exp_a.pop_front());
        void'(exp_d.pop_front());
        seen++;
      end
    end
  end

  task automatic finish_test(input int n);
    if (exp_a.size() != 0)
    begin
      $display("test %0d: %0d predicted writes never appeared on the bus", n, exp_a.size());
      test_errs++;
    end
    if (test_errs == 0)
    begin
      passed++;
      $display("test %0d passed, %0d bus writes", n, seen);
    end
    else
    begin
      failed++;
      $display("test %0d failed with %0d errors", n, test_errs);
    end
  endtask

endmodule

// File: bench/tb_cpu.sv
/* runs 5 random 60-instruction programs on a 128 KB byte memory model; rdy_in and
   io_buffer_full toggle at random, test 3 carries an illegal opcode */
`include "cpu_cfg.svh"
`timescale 1ns/10ps

module tb_cpu;
  import cpu_pkg::*;

  localparam int          TESTS        = 5;
  localparam int          PROG_LEN     = 60;
  localparam int          TIMEOUT      = TESTS * PROG_LEN * 40;  // 40 cycles per instruction
  localparam int          RESET_CYCLES = 5;
  localparam int          ILLEGAL_TEST = 3;
  localparam logic [31:0] SEED         = 32'h88b6_d35c;

  logic        clk_in;
  logic        arst_n;
  logic        rdy_in;
  logic        io_buffer_full;
  byte_t       mem_din;
  byte_t       mem_dout;
  logic [31:0] mem_a;
  logic        mem_wr;
  byte_t       ram [`CPU_RAM_BYTES];
  int          cycles;
  int          full_left;  // cycles left in an io_buffer_full burst

  cpu cpu_inst
  (
    .clk_in         (clk_in),
    .arst_n         (arst_n),
    .rdy_in         (rdy_in),
    .mem_din        (mem_din),
    .mem_dout       (mem_dout),
    .mem_a          (mem_a),
    .mem_wr         (mem_wr),
    .io_buffer_full (io_buffer_full)
  );

  cpu_checker checker_inst
  (
    .clk_in   (clk_in),
    .rdy_in   (rdy_in),
    .mem_wr   (mem_wr),
    .mem_a    (mem_a),
    .mem_dout (mem_dout)
  );

  bind cpu cpu_assertions cpu_assertions_inst
  (
    .clk_in         (clk_in),
    .arst_n         (arst_n),
    .rdy_in         (rdy_in),
    .io_buffer_full (io_buffer_full),
    .mem_wr         (mem_wr),
    .mem_a          (mem_a),
    .mem_req        (mem_req),
    .mem_ack        (mem_ack)
  );

  always #50 clk_in = ~clk_in;

  // byte memory, read data one cycle after the address, IO writes not stored
  always @(posedge clk_in)
  begin
    if (mem_wr && (mem_a < `CPU_RAM_BYTES))
      ram[mem_a[16:0]] <= mem_dout;
    mem_din <= ram[mem_a[16:0]];
  end

  // rdy_in low about 1 cycle in 4, io_buffer_full in bursts of 1..8
  always @(posedge clk_in)
  begin
    rdy_in <= ($urandom_range(3, 0) != 0);
    if (full_left != 0)
    begin
      full_left      <= full_left - 1;
      io_buffer_full <= 1'b1;
    end
    else if ($urandom_range(15, 0) == 0)
    begin
      full_left      <= $urandom_range(7, 0);
      io_buffer_full <= 1'b1;
    end
    else
      io_buffer_full <= 1'b0;
  end

  always @(posedge clk_in)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT)
    begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  function automatic word_t encode_r(input logic [6:0] f7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3,
                                     input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic word_t encode_i(input logic [11:0] imm, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd,
                                     input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t encode_s(input logic [11:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t encode_b(input logic [12:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t encode_u(input logic [19:0] imm, input reg_idx_t rd);
    return {imm, rd, 7'b0110111};  // lui
  endfunction

  function automatic word_t encode_j(input logic [20:0] imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // both memories get the same byte
  task automatic put_byte(input word_t addr, input byte_t d);
    ram[addr[16:0]] = d;
    checker_inst.load_byte(addr, d);
  endtask

  task automatic put_word(input word_t addr, input word_t w);
    for (int k = 0; k < 4; k++)
      put_byte(addr + k, w[k*8 +: 8]);
  endtask

  task automatic emit(inout int slot, input word_t ins);
    put_word(word_t'(slot * 4), ins);
    slot++;
  endtask

  task automatic fill_data();
    for (int a = 32'h1_0000; a < 32'h1_1000; a += 4)
      put_word(word_t'(a), $urandom);
  endtask

  task automatic build_program(input int test_no);
    int         slot;
    int         skip;
    word_t      rnd;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       keep;   // follow with a store of rd
    slot = 0;
    emit(slot, encode_u(20'h00010, 5'd1));  // x1 = data region base
    emit(slot, encode_u(20'h00030, 5'd2));  // x2 = io base
    while (slot < PROG_LEN - 1)
    begin
      rnd  = $urandom;
      rd   = reg_idx_t'($urandom_range(31, 3));  // x1, x2 never overwritten
      rs1  = reg_idx_t'($urandom_range(31, 0));
      rs2  = reg_idx_t'($urandom_range(31, 0));
      keep = 1'b1;
      case ($urandom_range(9, 0))
        0: emit(slot, encode_u(rnd[19:0], rd));
        1, 2:
        begin
          do
            f3 = 3'($urandom_range(7, 0));
          while ((f3 == 3'd1) || (f3 == 3'd3) || (f3 == 3'd5));  // addi slti xori ori andi
          emit(slot, encode_i(rnd[11:0], rs1, f3, rd, 7'b0010011));
        end
        3, 4:
        begin
          do
            f3 = 3'($urandom_range(7, 0));
          while (f3 == 3'd3);
          f7 = ((f3 == 3'd0) && rnd[31]) ? 7'h20 : 7'h00;  // sub half the time
          emit(slot, encode_r(f7, rs2, rs1, f3, rd));
        end
        5:
          if (rnd[31])
            emit(slot, encode_i({1'b0, rnd[10:2], 2'b00}, 5'd1, 3'b010, rd, 7'b0000011));
          else
            emit(slot, encode_i({1'b0, rnd[10:0]}, 5'd1, 3'b100, rd, 7'b0000011));
        6:
        begin
          keep = 1'b0;
          if (rnd[31])
            emit(slot, encode_s({1'b0, rnd[10:2], 2'b00}, rs2, 5'd1, 3'b010));
          else
            emit(slot, encode_s({1'b0, rnd[10:0]}, rs2, 5'd1, 3'b000));
        end
        7:
        begin
          keep = 1'b0;
          emit(slot, encode_s(12'd0, rs2, 5'd2, 3'b000));  // byte to the uart
        end
        8:
        begin
          keep = 1'b0;
          if (rnd[0])
            rs2 = rs1;  // equal operands, beq taken and bne not
          skip = $urandom_range(4, 1);
          if (slot + skip > PROG_LEN - 1)
            skip = PROG_LEN - 1 - slot;
          emit(slot, encode_b(13'(skip * 4), rs2, rs1, {2'b00, rnd[1]}));
        end
        default:
          if (slot <= PROG_LEN - 4)
          begin
            emit(slot, encode_j(21'd8, rd));
            emit(slot, encode_s({1'b0, rnd[10:2], 2'b00}, rs2, 5'd1, 3'b010));  // jumped over
          end
          else
            emit(slot, encode_u(rnd[19:0], rd));
      endcase
      if (keep && (slot < PROG_LEN - 1))
        emit(slot, encode_s({1'b0, rnd[22:14], 2'b00}, rd, 5'd1, 3'b010));
    end
    emit(slot, encode_s(12'd4, rs2, 5'd2, 3'b010));  // halt
    if (test_no == ILLEGAL_TEST)
      put_word(word_t'(4 * $urandom_range(50, 10)), 32'hFFFF_FFFF);
  endtask

  initial
  begin
    clk_in         = 1'b0;
    arst_n         = 1'b0;
    rdy_in         = 1'b1;
    io_buffer_full = 1'b0;
    mem_din        = '0;
    cycles         = 0;
    full_left      = 0;
    void'($urandom(SEED));
    for (int i = 0; i < `CPU_RAM_BYTES; i++)
      ram[i] = byte_t'(i ^ (i >> 8) ^ (i >> 16));  // every address bit shows up
    for (int t = 0; t < TESTS; t++)
    begin
      @(posedge clk_in);
      arst_n <= 1'b0;
      fill_data();
      build_program(t);
      checker_inst.run_model();
      repeat (RESET_CYCLES) @(posedge clk_in);
      arst_n <= 1'b1;
      while (cpu_inst.core_ctrl_inst.state != HALTED)
        @(posedge clk_in);
      repeat (20) @(posedge clk_in);  // any write after the halt is caught here
      @(negedge clk_in);
      checker_inst.finish_test(t);
    end
    $display("tests passed %0d failed %0d, assertion failures %0d", checker_inst.passed,
             checker_inst.failed, cpu_inst.cpu_assertions_inst.violations);
    if ((checker_inst.failed == 0) && (cpu_inst.cpu_assertions_inst.violations == 0))
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: src.f
+incdir+logic
logic/cpu_pkg.sv
logic/mem_ctrl.sv
logic/decoder.sv
logic/alu.sv
logic/reg_file.sv
logic/core_ctrl.sv
logic/cpu.sv
bench/cpu_assertions.sv
bench/cpu_checker.sv
bench/tb_cpu.sv
